// File: design/core.sv
`timescale 1ns/1ps

module core (
    input  logic                       clock_i,
    input  logic                       rst_i,
    input  core_pkg::fetch_word_t      imem_data_i,
    output core_pkg::imem_addr_t       imem_addr_o,
    output logic                       imem_stall_o,
    output core_pkg::wb_t        [1:0] retire_o
);

    core_pkg::word_t                fetch_pc;
    logic                           fetch_valid;
    logic                           stall;
    core_pkg::uop_t           [1:0] dec_uop;
    core_pkg::reg_addr_t      [3:0] rf_raddr;
    core_pkg::word_t          [3:0] rf_rdata;
    core_pkg::uop_t           [1:0] exe_uop;
    core_pkg::word_t     [1:0][1:0] exe_opnd;
    core_pkg::wb_t            [1:0] wb;

    // a split pair also freezes the memory output
    assign imem_stall_o = stall;
    assign retire_o     = wb;

    fetch i_fetch (
        .clock_i       (clock_i),
        .rst_i         (rst_i),
        .stall_i       (stall),
        .imem_addr_o   (imem_addr_o),
        .fetch_pc_o    (fetch_pc),
        .fetch_valid_o (fetch_valid)
    );

    decode i_decode (
        .clock_i       (clock_i),
        .rst_i         (rst_i),
        .stall_i       (stall),
        .imem_data_i   (imem_data_i),
        .fetch_pc_i    (fetch_pc),
        .fetch_valid_i (fetch_valid),
        .uop_o         (dec_uop)
    );

    issue i_issue (
        .clock_i (clock_i),
        .rst_i   (rst_i),
        .uop_i   (dec_uop),
        .raddr_o (rf_raddr),
        .rdata_i (rf_rdata),
        .stall_o (stall),
        .uop_o   (exe_uop),
        .opnd_o  (exe_opnd)
    );

    regfile i_regfile (
        .clock_i (clock_i),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .wb_i    (wb)
    );

    execute i_execute (
        .clock_i (clock_i),
        .rst_i   (rst_i),
        .uop_i   (exe_uop),
        .opnd_i  (exe_opnd),
        .wb_o    (wb)
    );

endmodule

// File: design/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;
    typedef logic [`CORE_IMEM_AW-1:0] imem_addr_t;

    // lane 0 in the low half
    typedef logic [`CORE_FETCH_W-1:0] fetch_word_t;

    // lui is an add of the immediate to x0
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // one decoded instruction
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      reg_write;
        logic      use_imm;
        word_t     imm;
        alu_op_e   alu_op;
    } uop_t;

    // one writeback slot, also the retire trace
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      reg_write;
        word_t     data;
    } wb_t;

endpackage

// File: design/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path and register file
`define CORE_XLEN 32
`define CORE_NREGS 32

// instruction memory, word addressed
`define CORE_IMEM_AW 10
`define CORE_FETCH_W 64

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: design/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                       clock_i,
    input  logic                       rst_i,
    input  logic                       stall_i,
    input  core_pkg::fetch_word_t      imem_data_i,
    input  core_pkg::word_t            fetch_pc_i,
    input  logic                       fetch_valid_i,
    output core_pkg::uop_t       [1:0] uop_o
);

    function automatic core_pkg::uop_t decode_inst(core_pkg::inst_t inst, core_pkg::word_t pc,
                                                   logic valid);
        core_pkg::uop_t u;
        logic           known;
        logic           is_op;
        u         = '0;
        u.pc      = pc;
        u.rd      = inst[11:7];
        u.rs1     = inst[19:15];
        u.rs2     = inst[24:20];
        u.use_imm = 1'b1;
        u.alu_op  = core_pkg::alu_add;
        known     = 1'b1;
        is_op     = 1'b0;
        case (inst[6:0])
            // lui
            7'b0110111: begin
                u.imm = {inst[31:12], 12'b0};
                u.rs1 = '0;
                u.rs2 = '0;
            end
            // op-imm, rs2 field is part of the immediate
            7'b0010011: begin
                u.imm = {{20{inst[31]}}, inst[31:20]};
                u.rs2 = '0;
            end
            7'b0110011: begin
                is_op     = 1'b1;
                u.use_imm = 1'b0;
            end
            default: known = 1'b0;
        endcase
        if (inst[6:0] != 7'b0110111) begin
            case (inst[14:12])
                3'b000:  u.alu_op = (is_op && inst[30]) ? core_pkg::alu_sub : core_pkg::alu_add;
                3'b001:  u.alu_op = core_pkg::alu_sll;
                3'b010:  u.alu_op = core_pkg::alu_slt;
                3'b011:  u.alu_op = core_pkg::alu_sltu;
                3'b100:  u.alu_op = core_pkg::alu_xor;
                3'b101:  u.alu_op = inst[30] ? core_pkg::alu_sra : core_pkg::alu_srl;
                3'b110:  u.alu_op = core_pkg::alu_or;
                default: u.alu_op = core_pkg::alu_and;
            endcase
        end
        u.valid     = valid && known;
        // x0 is never written
        u.reg_write = known && (u.rd != '0);
        return u;
    endfunction

    core_pkg::uop_t [1:0] uop_d;
    core_pkg::uop_t [1:0] uop_q;

    assign uop_d[0] = decode_inst(imem_data_i[31:0], fetch_pc_i, fetch_valid_i);
    assign uop_d[1] = decode_inst(imem_data_i[63:32], fetch_pc_i + 32'd4, fetch_valid_i);

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            uop_q <= uop_d;
        end
        if (rst_i) begin
            uop_q[0].valid <= 1'b0;
            uop_q[1].valid <= 1'b0;
        end
    end

    assign uop_o = uop_q;

endmodule

// File: design/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                            clock_i,
    input  logic                            rst_i,
    input  core_pkg::uop_t            [1:0] uop_i,
    input  core_pkg::word_t      [1:0][1:0] opnd_i,
    output core_pkg::wb_t             [1:0] wb_o
);

    core_pkg::wb_t   [1:0] wb_q;
    core_pkg::wb_t   [1:0] wb_d;
    core_pkg::word_t [1:0] src_a;
    core_pkg::word_t [1:0] src_b;

    // bypass from the writeback register, lane 1 is younger
    function automatic core_pkg::word_t fwd(core_pkg::reg_addr_t rs, core_pkg::word_t v,
                                            core_pkg::wb_t [1:0] wb);
        core_pkg::word_t r;
        r = v;
        for (int w = 0; w < 2; w++) begin
            if (wb[w].valid && wb[w].reg_write && wb[w].rd == rs && rs != '0) begin
                r = wb[w].data;
            end
        end
        return r;
    endfunction

    function automatic core_pkg::word_t alu(core_pkg::alu_op_e op, core_pkg::word_t a,
                                            core_pkg::word_t b);
        case (op)
            core_pkg::alu_sub:  return a - b;
            core_pkg::alu_sll:  return a << b[4:0];
            core_pkg::alu_slt:  return core_pkg::word_t'($signed(a) < $signed(b));
            core_pkg::alu_sltu: return core_pkg::word_t'(a < b);
            core_pkg::alu_xor:  return a ^ b;
            core_pkg::alu_srl:  return a >> b[4:0];
            core_pkg::alu_sra:  return core_pkg::word_t'($signed(a) >>> b[4:0]);
            core_pkg::alu_or:   return a | b;
            core_pkg::alu_and:  return a & b;
            default:            return a + b;
        endcase
    endfunction

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            src_a[l] = fwd(uop_i[l].rs1, opnd_i[l][0], wb_q);
            src_b[l] = uop_i[l].use_imm ? uop_i[l].imm : fwd(uop_i[l].rs2, opnd_i[l][1], wb_q);
            wb_d[l].valid     = uop_i[l].valid;
            wb_d[l].pc        = uop_i[l].pc;
            wb_d[l].rd        = uop_i[l].rd;
            wb_d[l].reg_write = uop_i[l].reg_write;
            wb_d[l].data      = (uop_i[l].rd == '0) ? '0 : alu(uop_i[l].alu_op, src_a[l], src_b[l]);
        end
    end

    always_ff @(posedge clock_i) begin
        wb_q <= wb_d;
        if (rst_i) begin
            wb_q[0].valid <= 1'b0;
            wb_q[1].valid <= 1'b0;
        end
    end

    assign wb_o = wb_q;

endmodule

// File: design/fetch.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch (
    input  logic                 clock_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    output core_pkg::imem_addr_t imem_addr_o,
    output core_pkg::word_t      fetch_pc_o,
    output logic                 fetch_valid_o
);

    // pc of the word being addressed now
    core_pkg::word_t pc_q;
    // pc of the word arriving on the memory data
    core_pkg::word_t prev_pc_q;
    logic            valid_q;

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            pc_q    <= `CORE_RESET_PC;
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            pc_q    <= pc_q + core_pkg::word_t'(`CORE_FETCH_W / 8);
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            prev_pc_q <= pc_q;
        end
    end

    // byte address to 64-bit word address
    assign imem_addr_o   = pc_q[`CORE_IMEM_AW+2:3];
    assign fetch_pc_o    = prev_pc_q;
    assign fetch_valid_o = valid_q;

endmodule

// File: design/issue.sv
`timescale 1ns/1ps

module issue (
    input  logic                            clock_i,
    input  logic                            rst_i,
    input  core_pkg::uop_t            [1:0] uop_i,
    output core_pkg::reg_addr_t       [3:0] raddr_o,
    input  core_pkg::word_t           [3:0] rdata_i,
    output logic                            stall_o,
    output core_pkg::uop_t            [1:0] uop_o,
    output core_pkg::word_t      [1:0][1:0] opnd_o
);

    // lane 0 of the held pair has gone already
    logic                      sent0_q;
    logic                      dep;
    logic                      split;
    core_pkg::uop_t      [1:0] uop_d;
    core_pkg::uop_t      [1:0] uop_q;
    core_pkg::word_t [1:0][1:0] opnd_q;

    assign raddr_o[0] = uop_i[0].rs1;
    assign raddr_o[1] = uop_i[0].rs2;
    assign raddr_o[2] = uop_i[1].rs1;
    assign raddr_o[3] = uop_i[1].rs2;

    // reg_write is never set for x0, and unused sources read x0
    assign dep = uop_i[0].valid && uop_i[0].reg_write && uop_i[1].valid &&
                 (uop_i[1].rs1 == uop_i[0].rd || uop_i[1].rs2 == uop_i[0].rd);

    assign split   = !sent0_q && dep;
    assign stall_o = split;

    always_comb begin
        uop_d          = uop_i;
        uop_d[0].valid = uop_i[0].valid && !sent0_q;
        uop_d[1].valid = uop_i[1].valid && !split;
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            sent0_q <= 1'b0;
        end else begin
            sent0_q <= split;
        end
    end

    always_ff @(posedge clock_i) begin
        uop_q        <= uop_d;
        opnd_q[0][0] <= rdata_i[0];
        opnd_q[0][1] <= rdata_i[1];
        opnd_q[1][0] <= rdata_i[2];
        opnd_q[1][1] <= rdata_i[3];
        if (rst_i) begin
            uop_q[0].valid <= 1'b0;
            uop_q[1].valid <= 1'b0;
        end
    end

    assign uop_o  = uop_q;
    assign opnd_o = opnd_q;

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module regfile (
    input  logic                        clock_i,
    input  core_pkg::reg_addr_t   [3:0] raddr_i,
    output core_pkg::word_t       [3:0] rdata_o,
    input  core_pkg::wb_t         [1:0] wb_i
);

    core_pkg::word_t regs [1:`CORE_NREGS-1];

    // lane 1 written last so it wins a collision
    always_ff @(posedge clock_i) begin
        for (int w = 0; w < 2; w++) begin
            if (wb_i[w].valid && wb_i[w].reg_write && wb_i[w].rd != '0) begin
                regs[wb_i[w].rd] <= wb_i[w].data;
            end
        end
    end

    // write-through, lane 1 checked first
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else if (wb_i[1].valid && wb_i[1].reg_write && wb_i[1].rd == raddr_i[p]) begin
                rdata_o[p] = wb_i[1].data;
            end else if (wb_i[0].valid && wb_i[0].reg_write && wb_i[0].rd == raddr_i[p]) begin
                rdata_o[p] = wb_i[0].data;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# compiles the core and its testbench with verilator, then runs it
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 -f vlog.f --top-module tb_core -o tb_core_sim
sim_out=$(./obj_dir/tb_core_sim || true)
echo "$sim_out"
if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi

// File: test/tb_core.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core;

    localparam int imem_words = 1 << `CORE_IMEM_AW;
    localparam int timeout_cycles = 400;
    localparam logic [6:0] opc_lui = 7'h37;
    localparam logic [6:0] opc_imm = 7'h13;
    localparam logic [6:0] opc_op = 7'h33;

    logic                        clock_i = 1'b0;
    logic                        rst_i = 1'b1;
    logic [`CORE_FETCH_W-1:0]    imem_data_i = '0;
    logic [`CORE_IMEM_AW-1:0]    imem_addr_o;
    logic                        imem_stall_o;
    core_pkg::wb_t         [1:0] retire_o;

    logic [`CORE_FETCH_W-1:0]    imem [0:imem_words-1];
    logic [`CORE_IMEM_AW-1:0]    rd_addr = '0;
    core_pkg::word_t             model_regs [0:31];
    core_pkg::word_t             prog [$];
    core_pkg::word_t             exp_pc [$];
    core_pkg::word_t             exp_rd [$];
    core_pkg::word_t             exp_we [$];
    core_pkg::word_t             exp_data [$];
    logic                        stall_seen;
    integer                      seed;

    core i_core (
        .clock_i      (clock_i),
        .rst_i        (rst_i),
        .imem_data_i  (imem_data_i),
        .imem_addr_o  (imem_addr_o),
        .imem_stall_o (imem_stall_o),
        .retire_o     (retire_o)
    );

    always #2 clock_i = ~clock_i;

    // memory holds its output register while stalled
    always @(posedge clock_i) begin
        if (!imem_stall_o) begin
            rd_addr <= imem_addr_o;
        end
    end

    always @(negedge clock_i) begin
        imem_data_i <= imem[rd_addr];
    end

    task automatic stop_sim(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(string what, core_pkg::word_t got, core_pkg::word_t expected);
        if (got !== expected) begin
            stop_sim($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, expected));
        end
    endtask

    function automatic core_pkg::word_t make_imm(logic [2:0] f3, int rd, int rs1,
                                                 logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), opc_imm};
    endfunction

    function automatic core_pkg::word_t make_reg(logic [6:0] f7, logic [2:0] f3, int rd,
                                                 int rs1, int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
    endfunction

    function automatic core_pkg::word_t make_lui(int rd, logic [19:0] upper);
        return {upper, 5'(rd), opc_lui};
    endfunction

    // lui then addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(int rd, core_pkg::word_t v);
        core_pkg::word_t upper;
        upper = (v + 32'h0000_0800) >> 12;
        prog.push_back(make_lui(rd, upper[19:0]));
        prog.push_back(make_imm(3'd0, rd, rd, v[11:0]));
    endtask

    // ISA model of one instruction where unknown opcodes retire nothing
    task automatic model_step(core_pkg::word_t inst, core_pkg::word_t pc);
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t res;
        logic [4:0]      rd;
        logic            known;
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        rd    = inst[11:7];
        res   = '0;
        known = 1'b1;
        if (inst[6:0] == opc_imm) begin
            b = {{20{inst[31]}}, inst[31:20]};
        end
        if (inst[6:0] == opc_lui) begin
            res = {inst[31:12], 12'h000};
        end else if (inst[6:0] == opc_imm || inst[6:0] == opc_op) begin
            case (inst[14:12])
                3'd0: res = (inst[6:0] == opc_op && inst[30]) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: res = inst[30] ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else begin
            known = 1'b0;
        end
        if (known) begin
            if (rd != 5'd0) begin
                model_regs[rd] = res;
            end
            exp_pc.push_back(pc);
            exp_rd.push_back(core_pkg::word_t'(rd));
            exp_we.push_back((rd == 5'd0) ? 32'd0 : 32'd1);
            exp_data.push_back((rd == 5'd0) ? 32'd0 : res);
        end
    endtask

    task automatic apply_reset();
        rst_i = 1'b1;
        for (int c = 0; c < 3; c++) begin
            @(negedge clock_i);
            check_equal("retire valid 0 in reset", 32'(retire_o[0].valid), 32'd0);
            check_equal("retire valid 1 in reset", 32'(retire_o[1].valid), 32'd0);
            check_equal("imem stall in reset", 32'(imem_stall_o), 32'd0);
            check_equal("imem address in reset", 32'(imem_addr_o), 32'd0);
        end
        rst_i = 1'b0;
        @(negedge clock_i);
        check_equal("retire valid 0 after reset", 32'(retire_o[0].valid), 32'd0);
        check_equal("retire valid 1 after reset", 32'(retire_o[1].valid), 32'd0);
        check_equal("imem stall after reset", 32'(imem_stall_o), 32'd0);
    endtask

    // lane 0 is older than lane 1
    task automatic check_retire();
        if (imem_stall_o) begin
            stall_seen = 1'b1;
        end
        for (int l = 0; l < 2; l++) begin
            if (retire_o[l].valid) begin
                if (exp_pc.size() == 0) begin
                    stop_sim($sformatf("unexpected retire of pc %h in lane %0d at %0t",
                                       retire_o[l].pc, l, $time));
                end else begin
                    check_equal("retire pc", retire_o[l].pc, exp_pc[0]);
                    check_equal("retire rd", core_pkg::word_t'(retire_o[l].rd), exp_rd[0]);
                    check_equal("retire reg_write", core_pkg::word_t'(retire_o[l].reg_write),
                                exp_we[0]);
                    check_equal("retire data", retire_o[l].data, exp_data[0]);
                    void'(exp_pc.pop_front());
                    void'(exp_rd.pop_front());
                    void'(exp_we.pop_front());
                    void'(exp_data.pop_front());
                end
            end
        end
    endtask

    // program into the memory model and expected retires from the ISA model
    task automatic load_program();
        for (int w = 0; w < imem_words; w++) begin
            imem[w] = '0;
        end
        exp_pc.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_data.delete();
        foreach (prog[i]) begin
            if (i % 2 == 0) begin
                imem[i / 2][31:0] = prog[i];
            end else begin
                imem[i / 2][63:32] = prog[i];
            end
            model_step(prog[i], core_pkg::word_t'(4 * i));
        end
    endtask

    task automatic run_program();
        int cycles;
        load_program();
        apply_reset();
        stall_seen = 1'b0;
        cycles     = 0;
        while (exp_pc.size() > 0) begin
            @(negedge clock_i);
            check_retire();
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_sim($sformatf("timed out with %0d instructions not retired", exp_pc.size()));
            end
        end
        // bubbles behind the program must not retire
        for (int c = 0; c < 10; c++) begin
            @(negedge clock_i);
            check_retire();
        end
    endtask

    task automatic reset_in_flight();
        int cycles;
        prog.delete();
        // dependent pairs keep the pipeline busy and stalling
        for (int i = 0; i < 16; i++) begin
            prog.push_back(make_imm(3'd0, 1, 0, 12'(i + 1)));
            prog.push_back(make_imm(3'd0, 2, 1, 12'd3));
        end
        load_program();
        apply_reset();
        cycles = 0;
        while (!(retire_o[0].valid && imem_stall_o)) begin
            @(negedge clock_i);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_sim("pipeline never got busy before the reset in flight");
            end
        end
        // reset with instructions in flight and then the whole program again
        apply_reset();
        run_program();
    endtask

    task automatic independent_pairs();
        prog.delete();
        for (int i = 0; i < 6; i++) begin
            prog.push_back(make_lui(1 + i, 20'($random(seed))));
            prog.push_back(make_imm(3'd0, 16 + i, 0, 12'($random(seed))));
        end
        run_program();
        check_equal("stall during independent pairs", 32'(stall_seen), 32'd0);
    endtask

    task automatic dependent_split();
        prog.delete();
        prog.push_back(make_imm(3'd0, 1, 0, 12'd5));
        prog.push_back(make_imm(3'd0, 2, 1, 12'd3));
        prog.push_back(make_imm(3'd0, 3, 0, -12'sd7));
        prog.push_back(make_reg(7'h00, 3'd0, 4, 2, 3));
        // same destination pairs both dependent and independent
        prog.push_back(make_imm(3'd0, 5, 0, 12'd1));
        prog.push_back(make_imm(3'd0, 5, 5, 12'd1));
        prog.push_back(make_imm(3'd0, 6, 0, 12'd9));
        prog.push_back(make_imm(3'd0, 6, 0, 12'd12));
        prog.push_back(make_imm(3'd1, 7, 5, 12'd4));
        prog.push_back(make_reg(7'h20, 3'd0, 8, 7, 6));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(make_imm(3'd0, 0, 0, 12'd0));
        end
        prog.push_back(make_reg(7'h00, 3'd0, 9, 5, 6));
        prog.push_back(make_reg(7'h00, 3'd0, 24, 4, 8));
        run_program();
        check_equal("stall during dependent pairs", 32'(stall_seen), 32'd1);
    endtask

    task automatic forwarding_chains();
        prog.delete();
        prog.push_back(make_imm(3'd0, 10, 0, 12'd100));
        prog.push_back(make_imm(3'd0, 11, 0, -12'sd50));
        // distance one pair
        for (int i = 0; i < 3; i++) begin
            prog.push_back(make_imm(3'd0, 10, 10, 12'd7));
            prog.push_back(make_imm(3'd0, 11, 11, -12'sd3));
        end
        prog.push_back(make_imm(3'd0, 12, 10, 12'd3));
        prog.push_back(make_imm(3'd0, 13, 11, 12'd4));
        prog.push_back(make_imm(3'd0, 14, 0, 12'd1));
        prog.push_back(make_imm(3'd0, 15, 0, 12'd2));
        // distance two pairs
        prog.push_back(make_reg(7'h00, 3'd0, 16, 12, 13));
        prog.push_back(make_reg(7'h20, 3'd0, 17, 13, 12));
        prog.push_back(make_reg(7'h00, 3'd0, 18, 16, 14));
        prog.push_back(make_reg(7'h00, 3'd4, 19, 17, 15));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(make_imm(3'd0, 0, 0, 12'd0));
        end
        // read back final values
        prog.push_back(make_reg(7'h00, 3'd0, 20, 10, 0));
        prog.push_back(make_reg(7'h00, 3'd0, 21, 11, 0));
        prog.push_back(make_reg(7'h00, 3'd0, 22, 18, 0));
        prog.push_back(make_reg(7'h00, 3'd0, 23, 19, 0));
        run_program();
    endtask

    task automatic alu_operations();
        core_pkg::word_t a;
        core_pkg::word_t b;
        logic [11:0]     imm;
        logic [4:0]      sh;
        prog.delete();
        for (int r = 0; r < 4; r++) begin
            a   = $random(seed);
            b   = $random(seed);
            imm = 12'($random(seed));
            sh  = 5'($random(seed));
            if (r == 0) begin
                a[31] = 1'b1;
                b[31] = 1'b0;
            end
            if (r == 1) begin
                b = a;
            end
            if (r == 2) begin
                a[31]   = 1'b0;
                b[31]   = 1'b1;
                imm[11] = 1'b1;
            end
            load_const(1, a);
            load_const(2, b);
            for (int f3 = 0; f3 < 8; f3++) begin
                prog.push_back(make_reg(7'h00, 3'(f3), 3 + f3, 1, 2));
            end
            prog.push_back(make_reg(7'h20, 3'd0, 11, 1, 2));
            prog.push_back(make_reg(7'h20, 3'd5, 12, 1, 2));
            prog.push_back(make_imm(3'd0, 13, 1, imm));
            prog.push_back(make_imm(3'd2, 14, 1, imm));
            prog.push_back(make_imm(3'd3, 15, 1, imm));
            prog.push_back(make_imm(3'd4, 16, 1, imm));
            prog.push_back(make_imm(3'd6, 17, 1, imm));
            prog.push_back(make_imm(3'd7, 18, 1, imm));
            prog.push_back(make_imm(3'd1, 19, 1, {7'h00, sh}));
            prog.push_back(make_imm(3'd5, 20, 1, {7'h00, sh}));
            prog.push_back(make_imm(3'd5, 21, 1, {7'h20, sh}));
            prog.push_back(make_reg(7'h00, 3'd0, 0, 1, 2));
            prog.push_back(make_imm(3'd0, 0, 1, imm));
        end
        run_program();
    endtask

    task automatic unsupported_opcodes();
        prog.delete();
        prog.push_back(make_imm(3'd0, 25, 0, 12'd11));
        // lw x1, 0(x0)
        prog.push_back(32'h0000_2083);
        prog.push_back(32'hffff_ffff);
        prog.push_back(make_imm(3'd0, 26, 25, 12'd5));
        // beq and jal
        prog.push_back(32'h0000_0063);
        prog.push_back(32'h0000_00ef);
        prog.push_back(make_reg(7'h00, 3'd0, 27, 25, 26));
        prog.push_back(make_imm(3'd0, 28, 27, -12'sd1));
        prog.push_back(32'h0000_0000);
        prog.push_back(32'h0010_0073);
        prog.push_back(make_imm(3'd0, 29, 28, 12'd1));
        prog.push_back(make_reg(7'h00, 3'd0, 30, 29, 27));
        run_program();
    endtask

    initial begin
        seed = 72;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        reset_in_flight();
        independent_pairs();
        dependent_split();
        forwarding_chains();
        alu_operations();
        unsupported_opcodes();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/core_pkg.sv
design/fetch.sv
design/decode.sv
design/regfile.sv
design/issue.sv
design/execute.sv
design/core.sv
test/tb_core.sv
